// File: src/coh_pkg.sv
//----------------------------------------
// coherence bus package
// bus messages, address widths and the
// entry kinds the line directory hands out
//----------------------------------------
package coh_pkg;

	// snooping bus messages, NONE means no request
	typedef enum logic [1:0] {
		MSG_NONE = 2'd0,
		GET_S    = 2'd1,
		GET_M    = 2'd2,
		PUT_M    = 2'd3
	} bus_msg_e;

	localparam int ADDR_W     = 16;   // word address
	localparam int LINE_IDX_W = 13;   // addr[15:3]
	localparam int LINE_NUM   = 8192;
	localparam int RSP_PTR_W  = 3;    // bus response queue pointer

	// cache side split of the line index
	localparam int DC_TAG_W   = 8;
	localparam int DC_IDX_W   = 5;

	// kind of issue queue entry made for a request
	typedef enum logic [1:0] {
		ALLOC_LOAD       = 2'd0,
		ALLOC_STORE_DATA = 2'd1,   // PUT_M, data comes with the request
		ALLOC_STORE_WAIT = 2'd2    // owner still has to supply the line
	} alloc_kind_e;

endpackage

// File: src/mem_pkg.sv
//----------------------------------------
// memory side package
// command encoding, tag and data widths
// and the depth of both queues
//----------------------------------------
package mem_pkg;

	// memory port commands
	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_LOAD  = 2'd1,
		CMD_STORE = 2'd2
	} mem_cmd_e;

	localparam int DATA_W     = 64;
	localparam int TAG_W      = 4;    // tag 0 = no response

	// miss status queues
	localparam int MSHR_NUM   = 4;
	localparam int MSHR_IDX_W = 2;

endpackage

// File: src/mem_issue_if.sv
//----------------------------------------
// memory issue interface
// head command of the issue queue, seen by
// the memory port and the response queue
//----------------------------------------
`timescale 1ns/1ns

interface mem_issue_if;

	mem_pkg::mem_cmd_e               cmd;
	logic [coh_pkg::ADDR_W-1:0]      addr;
	logic [mem_pkg::DATA_W-1:0]      data;
	logic [coh_pkg::RSP_PTR_W-1:0]   ptr;     // bus queue pointer of the head
	logic                            accept;  // memory took the command
	logic                            blocked; // response queue cannot take a load

	modport src  (output cmd, addr, data, ptr, input accept, blocked);
	modport sink (input cmd, addr, data, output accept);
	modport mon  (input cmd, ptr, accept, output blocked);

endinterface

// File: src/line_dir.sv
//----------------------------------------
// line directory
// one dirty bit per memory line, decides
// the bus acknowledge and queue allocation
//----------------------------------------
`timescale 1ns/1ns

module line_dir (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [coh_pkg::LINE_IDX_W-1:0]   bus_req_addr_i,
	input  coh_pkg::bus_msg_e                bus_req_msg_i,
	input  logic                             bus_req_core_ack_i,
	input  logic                             bus_req_ack_i,
	input  logic                             full_i,
	output logic                             rsp_ack_o,
	output logic                             alloc_o,
	output coh_pkg::alloc_kind_e             alloc_kind_o
);

	logic [coh_pkg::LINE_NUM-1:0]   dirty_r;   // line owned in M by some cache
	logic                           line_dirty;
	logic                           need_alloc;
	logic                           dirty_wr;  // flip the bit on commit
	logic                           commit;

	assign line_dirty = dirty_r[bus_req_addr_i];
	assign commit     = bus_req_ack_i && rsp_ack_o;
	assign alloc_o    = commit && need_alloc;

	always_comb begin
		rsp_ack_o    = 1'b0;
		need_alloc   = 1'b0;
		dirty_wr     = 1'b0;
		alloc_kind_o = coh_pkg::ALLOC_LOAD;
		if (!line_dirty) begin
			case (bus_req_msg_i)
				coh_pkg::GET_M: begin   // clean -> M, no memory work
					rsp_ack_o = 1'b1;
					dirty_wr  = 1'b1;
				end
				coh_pkg::GET_S: begin
					if (!bus_req_core_ack_i) begin   // no cache answers, memory does
						rsp_ack_o  = !full_i;
						need_alloc = 1'b1;
					end
				end
				default: rsp_ack_o = 1'b0;
			endcase
		end else begin
			case (bus_req_msg_i)
				coh_pkg::PUT_M: begin   // writeback carries the data
					rsp_ack_o    = !full_i;
					need_alloc   = 1'b1;
					dirty_wr     = 1'b1;
					alloc_kind_o = coh_pkg::ALLOC_STORE_DATA;
				end
				coh_pkg::GET_S: begin   // owner will put the line on the bus
					rsp_ack_o    = !full_i;
					need_alloc   = 1'b1;
					dirty_wr     = 1'b1;
					alloc_kind_o = coh_pkg::ALLOC_STORE_WAIT;
				end
				coh_pkg::GET_M: rsp_ack_o = 1'b1;   // M -> M, ownership moves
				default:        rsp_ack_o = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dirty_r <= '0;
		end else if (commit && dirty_wr) begin
			dirty_r[bus_req_addr_i] <= !line_dirty;
		end
	end

endmodule

// File: src/issue_queue.sv
//----------------------------------------
// issue queue
// circular miss status queue, holds memory
// commands until ready and accepted
//----------------------------------------
`timescale 1ns/1ns

module issue_queue (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             alloc_i,
	input  coh_pkg::alloc_kind_e             alloc_kind_i,
	input  logic [coh_pkg::ADDR_W-1:0]       req_addr_i,
	input  logic [mem_pkg::DATA_W-1:0]       req_data_i,
	input  logic [coh_pkg::RSP_PTR_W-1:0]    req_ptr_i,
	input  logic                             snoop_vld_i,
	input  logic [coh_pkg::ADDR_W-1:0]       snoop_addr_i,
	input  logic [mem_pkg::DATA_W-1:0]       snoop_data_i,
	output logic                             full_o,
	mem_issue_if.src                         iss
);

	//----------------------------------------
	// entry storage
	//----------------------------------------
	logic [mem_pkg::MSHR_NUM-1:0]    vld_r;
	logic [mem_pkg::MSHR_NUM-1:0]    rdy_r;   // low while waiting for owner data
	mem_pkg::mem_cmd_e               cmd_r  [mem_pkg::MSHR_NUM];
	logic [coh_pkg::ADDR_W-1:0]      addr_r [mem_pkg::MSHR_NUM];
	logic [mem_pkg::DATA_W-1:0]      data_r [mem_pkg::MSHR_NUM];
	logic [coh_pkg::RSP_PTR_W-1:0]   ptr_r  [mem_pkg::MSHR_NUM];

	// pointers carry a wrap bit on top
	logic [mem_pkg::MSHR_IDX_W:0]    head_r;
	logic [mem_pkg::MSHR_IDX_W:0]    tail_r;
	logic [mem_pkg::MSHR_IDX_W-1:0]  head_idx;
	logic [mem_pkg::MSHR_IDX_W-1:0]  tail_idx;

	logic                            full;
	logic                            retire;
	logic                            head_go;
	logic [mem_pkg::MSHR_NUM-1:0]    snoop_hit;

	assign head_idx = head_r[mem_pkg::MSHR_IDX_W-1:0];
	assign tail_idx = tail_r[mem_pkg::MSHR_IDX_W-1:0];

	assign full   = (head_r[mem_pkg::MSHR_IDX_W] != tail_r[mem_pkg::MSHR_IDX_W]) &&
	                (head_idx == tail_idx);
	assign retire = iss.accept;
	assign full_o = full && !retire;   // a retiring head frees its slot

	//----------------------------------------
	// head command to memory
	//----------------------------------------
	assign head_go  = vld_r[head_idx] && rdy_r[head_idx] && !iss.blocked;
	assign iss.cmd  = head_go ? cmd_r[head_idx] : mem_pkg::CMD_NONE;
	assign iss.addr = addr_r[head_idx];
	assign iss.data = data_r[head_idx];
	assign iss.ptr  = ptr_r[head_idx];

	// owner data on the bus, every waiting entry on that address takes it
	always_comb begin
		for (int i = 0; i < mem_pkg::MSHR_NUM; i++) begin
			snoop_hit[i] = snoop_vld_i && vld_r[i] && (addr_r[i] == snoop_addr_i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
			vld_r  <= '0;
			rdy_r  <= '0;
		end else begin
			for (int i = 0; i < mem_pkg::MSHR_NUM; i++) begin
				if (snoop_hit[i])
					rdy_r[i] <= 1'b1;
			end
			if (retire) begin
				vld_r[head_idx] <= 1'b0;
				rdy_r[head_idx] <= 1'b0;
				head_r          <= head_r + 1'b1;
			end
			if (alloc_i) begin
				vld_r[tail_idx] <= 1'b1;
				rdy_r[tail_idx] <= (alloc_kind_i != coh_pkg::ALLOC_STORE_WAIT);
				tail_r          <= tail_r + 1'b1;
			end
		end
	end

	// payload
	always_ff @(posedge clk) begin
		for (int i = 0; i < mem_pkg::MSHR_NUM; i++) begin
			if (snoop_hit[i])
				data_r[i] <= snoop_data_i;
		end
		if (alloc_i) begin
			cmd_r[tail_idx]  <= (alloc_kind_i == coh_pkg::ALLOC_LOAD) ? mem_pkg::CMD_LOAD :
			                                                            mem_pkg::CMD_STORE;
			addr_r[tail_idx] <= req_addr_i;
			data_r[tail_idx] <= req_data_i;   // overwritten by snoop for a waiting store
			ptr_r[tail_idx]  <= req_ptr_i;
		end
	end

endmodule

// File: src/response_queue.sv
//----------------------------------------
// response queue
// tags of accepted loads in issue order,
// matched against returning memory tags
//----------------------------------------
`timescale 1ns/1ns

module response_queue (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [mem_pkg::TAG_W-1:0]        mem_tag_i,
	input  logic [mem_pkg::TAG_W-1:0]        mem_resp_i,
	mem_issue_if.mon                         mon,
	output logic                             data_rdy_o,
	output logic [coh_pkg::RSP_PTR_W-1:0]    rsp_ptr_o
);

	logic [mem_pkg::TAG_W-1:0]       tag_r [mem_pkg::MSHR_NUM];
	logic [coh_pkg::RSP_PTR_W-1:0]   ptr_r [mem_pkg::MSHR_NUM];

	logic [mem_pkg::MSHR_IDX_W:0]    head_r;   // msb is the wrap bit
	logic [mem_pkg::MSHR_IDX_W:0]    tail_r;
	logic [mem_pkg::MSHR_IDX_W-1:0]  head_idx;
	logic [mem_pkg::MSHR_IDX_W-1:0]  tail_idx;

	logic                            empty;
	logic                            full;
	logic                            push;

	assign head_idx = head_r[mem_pkg::MSHR_IDX_W-1:0];
	assign tail_idx = tail_r[mem_pkg::MSHR_IDX_W-1:0];

	assign empty = (head_r == tail_r);
	assign full  = (head_r[mem_pkg::MSHR_IDX_W] != tail_r[mem_pkg::MSHR_IDX_W]) &&
	               (head_idx == tail_idx);

	// only loads come back with data
	assign push = mon.accept && (mon.cmd == mem_pkg::CMD_LOAD);

	assign data_rdy_o = !empty && (mem_tag_i != '0) && (mem_tag_i == tag_r[head_idx]);
	assign rsp_ptr_o  = ptr_r[head_idx];

	assign mon.blocked = full && !data_rdy_o;   // no room for another load

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (data_rdy_o)
				head_r <= head_r + 1'b1;
			if (push)
				tail_r <= tail_r + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			tag_r[tail_idx] <= mem_resp_i;   // tag the memory gave on accept
			ptr_r[tail_idx] <= mon.ptr;
		end
	end

endmodule

// File: src/dmem_ctrl.sv
//----------------------------------------
// data memory controller top
// bus and memory ports around the line
// directory and the two miss queues
//----------------------------------------
`timescale 1ns/1ns

module dmem_ctrl (
	input  logic                             clk,
	input  logic                             rst,
	// bus request side
	input  logic [coh_pkg::DC_TAG_W-1:0]     bus_req_tag_i,
	input  logic [coh_pkg::DC_IDX_W-1:0]     bus_req_idx_i,
	input  coh_pkg::bus_msg_e                bus_req_msg_i,
	input  logic [mem_pkg::DATA_W-1:0]       bus_req_data_i,
	input  logic                             bus_req_core_ack_i,
	input  logic                             bus_req_ack_i,
	input  logic [coh_pkg::RSP_PTR_W-1:0]    bus_req_ptr_i,
	// owner data snooped from the bus
	input  logic                             bus_rsp_vld_i,
	input  logic [coh_pkg::ADDR_W-1:0]       bus_rsp_addr_i,
	input  logic [mem_pkg::DATA_W-1:0]       bus_rsp_data_i,
	output logic                             dmem_ctrl_rsp_ack_o,
	output logic                             dmem_ctrl_rsp_vld_o,
	output logic [coh_pkg::RSP_PTR_W-1:0]    dmem_ctrl_rsp_ptr_o,
	output logic [mem_pkg::DATA_W-1:0]       dmem_ctrl_rsp_data_o,
	// memory side
	input  logic [mem_pkg::TAG_W-1:0]        mem_resp_i,
	input  logic [mem_pkg::TAG_W-1:0]        mem_tag_i,
	input  logic [mem_pkg::DATA_W-1:0]       mem_data_i,
	output logic [coh_pkg::ADDR_W-1:0]       mem_addr_o,
	output logic [mem_pkg::DATA_W-1:0]       mem_data_o,
	output mem_pkg::mem_cmd_e                mem_cmd_o
);

	logic [coh_pkg::ADDR_W-1:0]   bus_req_addr;
	logic                         alloc;
	coh_pkg::alloc_kind_e         alloc_kind;
	logic                         iq_full;

	mem_issue_if iss_if ();

	assign bus_req_addr = {bus_req_tag_i, bus_req_idx_i, 3'b000};   // one word per line

	assign iss_if.accept        = (mem_resp_i != '0);
	assign mem_cmd_o            = iss_if.cmd;
	assign mem_addr_o           = iss_if.addr;
	assign mem_data_o           = iss_if.data;
	assign dmem_ctrl_rsp_data_o = mem_data_i;

	line_dir line_dir_i (
		.clk                (clk),
		.rst                (rst),
		.bus_req_addr_i     ({bus_req_tag_i, bus_req_idx_i}),
		.bus_req_msg_i      (bus_req_msg_i),
		.bus_req_core_ack_i (bus_req_core_ack_i),
		.bus_req_ack_i      (bus_req_ack_i),
		.full_i             (iq_full),
		.rsp_ack_o          (dmem_ctrl_rsp_ack_o),
		.alloc_o            (alloc),
		.alloc_kind_o       (alloc_kind)
	);

	issue_queue issue_queue_i (
		.clk          (clk),
		.rst          (rst),
		.alloc_i      (alloc),
		.alloc_kind_i (alloc_kind),
		.req_addr_i   (bus_req_addr),
		.req_data_i   (bus_req_data_i),
		.req_ptr_i    (bus_req_ptr_i),
		.snoop_vld_i  (bus_rsp_vld_i),
		.snoop_addr_i (bus_rsp_addr_i),
		.snoop_data_i (bus_rsp_data_i),
		.full_o       (iq_full),
		.iss          (iss_if.src)
	);

	response_queue response_queue_i (
		.clk        (clk),
		.rst        (rst),
		.mem_tag_i  (mem_tag_i),
		.mem_resp_i (mem_resp_i),
		.mon        (iss_if.mon),
		.data_rdy_o (dmem_ctrl_rsp_vld_o),
		.rsp_ptr_o  (dmem_ctrl_rsp_ptr_o)
	);

endmodule

// File: sim/dmem_model.sv
//----------------------------------------
// word memory model
// tagged accept, stores at once, load data
// back four cycles after accept
//----------------------------------------
`timescale 1ns/1ns

module dmem_model (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             stall_i,
	input  mem_pkg::mem_cmd_e                cmd_i,
	input  logic [coh_pkg::ADDR_W-1:0]       addr_i,
	input  logic [mem_pkg::DATA_W-1:0]       data_i,
	output logic [mem_pkg::TAG_W-1:0]        resp_o,
	output logic [mem_pkg::TAG_W-1:0]        tag_o,
	output logic [mem_pkg::DATA_W-1:0]       data_o
);

	logic [mem_pkg::DATA_W-1:0]   words [coh_pkg::LINE_NUM];
	logic [mem_pkg::TAG_W-1:0]    next_tag;
	logic [mem_pkg::TAG_W-1:0]    tag_pipe [4];   // return delay line
	logic [mem_pkg::DATA_W-1:0]   data_pipe [4];
	logic                         accept;
	int                           store_cnt;

	assign accept = (cmd_i != mem_pkg::CMD_NONE) && !stall_i;
	assign resp_o = accept ? next_tag : '0;
	assign tag_o  = tag_pipe[3];
	assign data_o = data_pipe[3];

	// default contents follow the line index
	initial begin
		for (int i = 0; i < coh_pkg::LINE_NUM; i++)
			words[i] = {4{3'b000, i[12:0]}};
	end

	always @(posedge clk) begin
		if (rst) begin
			next_tag  <= 4'd1;
			store_cnt <= 0;
			for (int i = 0; i < 4; i++) begin
				tag_pipe[i]  <= '0;
				data_pipe[i] <= '0;
			end
		end else begin
			for (int i = 3; i > 0; i--) begin
				tag_pipe[i]  <= tag_pipe[i-1];
				data_pipe[i] <= data_pipe[i-1];
			end
			tag_pipe[0]  <= '0;
			data_pipe[0] <= '0;
			if (accept) begin
				next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;   // skip 0
				if (cmd_i == mem_pkg::CMD_LOAD) begin
					tag_pipe[0]  <= next_tag;
					data_pipe[0] <= words[addr_i[15:3]];
				end else begin
					words[addr_i[15:3]] = data_i;
					store_cnt           <= store_cnt + 1;
				end
			end
		end
	end

	task automatic preload(input logic [15:0] addr, input logic [63:0] data);
		words[addr[15:3]] = data;
	endtask

	task automatic read_word(input logic [15:0] addr, output logic [63:0] data);
		data = words[addr[15:3]];
	endtask

endmodule

// File: sim/tb_dmem_ctrl.sv
//----------------------------------------
// testbench for the data memory controller
// directed bus tests against a memory model
//----------------------------------------
`timescale 1ns/1ns

module tb_dmem_ctrl;

	localparam int TIMEOUT_CYC = 2000;   // tests need about 600

	logic                 clk;
	logic                 rst;
	logic [12:0]          req_line;
	coh_pkg::bus_msg_e    req_msg;
	logic [63:0]          req_data;
	logic                 req_core_ack;
	logic                 req_ack;
	logic [2:0]           req_ptr;
	logic                 snp_vld;
	logic [15:0]          snp_addr;
	logic [63:0]          snp_data;
	logic                 rsp_ack;
	logic                 rsp_vld;
	logic [2:0]           rsp_ptr;
	logic [63:0]          rsp_data;
	logic [3:0]           mem_resp;
	logic [3:0]           mem_tag;
	logic [63:0]          mem_rdata;
	logic [15:0]          mem_addr;
	logic [63:0]          mem_wdata;
	mem_pkg::mem_cmd_e    mem_cmd;
	logic                 stall;
	int                   cycles = 0;

	logic [2:0]           got_ptr_q [$];   // load responses in arrival order
	logic [63:0]          got_data_q [$];

	dmem_ctrl dmem_ctrl_i (
		.clk                  (clk),
		.rst                  (rst),
		.bus_req_tag_i        (req_line[12:5]),
		.bus_req_idx_i        (req_line[4:0]),
		.bus_req_msg_i        (req_msg),
		.bus_req_data_i       (req_data),
		.bus_req_core_ack_i   (req_core_ack),
		.bus_req_ack_i        (req_ack),
		.bus_req_ptr_i        (req_ptr),
		.bus_rsp_vld_i        (snp_vld),
		.bus_rsp_addr_i       (snp_addr),
		.bus_rsp_data_i       (snp_data),
		.dmem_ctrl_rsp_ack_o  (rsp_ack),
		.dmem_ctrl_rsp_vld_o  (rsp_vld),
		.dmem_ctrl_rsp_ptr_o  (rsp_ptr),
		.dmem_ctrl_rsp_data_o (rsp_data),
		.mem_resp_i           (mem_resp),
		.mem_tag_i            (mem_tag),
		.mem_data_i           (mem_rdata),
		.mem_addr_o           (mem_addr),
		.mem_data_o           (mem_wdata),
		.mem_cmd_o            (mem_cmd)
	);

	dmem_model mem_i (
		.clk     (clk),
		.rst     (rst),
		.stall_i (stall),
		.cmd_i   (mem_cmd),
		.addr_i  (mem_addr),
		.data_i  (mem_wdata),
		.resp_o  (mem_resp),
		.tag_o   (mem_tag),
		.data_o  (mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// log every load response off the bus
	always @(negedge clk) begin
		if (!rst && rsp_vld) begin
			got_ptr_q.push_back(rsp_ptr);
			got_data_q.push_back(rsp_data);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYC) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			$display("Done: errors found");
			$fatal(1);
		end
	end

	//----------------------------------------
	// helpers
	//----------------------------------------
	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s = %h, expected %h", name, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// request stays on the bus until bus_idle
	task automatic send_req(input coh_pkg::bus_msg_e msg, input logic [12:0] line,
	                        input logic [63:0] data, input logic core_ack,
	                        input logic [2:0] ptr, input logic exp_ack);
		@(negedge clk);
		req_msg      = msg;
		req_line     = line;
		req_data     = data;
		req_core_ack = core_ack;
		req_ptr      = ptr;
		req_ack      = 1'b1;
		#1;
		check_val("dmem_ctrl_rsp_ack_o", 64'(rsp_ack), 64'(exp_ack));
	endtask

	task automatic bus_idle();
		@(negedge clk);
		req_msg      = coh_pkg::MSG_NONE;
		req_ack      = 1'b0;
		req_core_ack = 1'b0;
	endtask

	task automatic expect_quiet(input int n);
		repeat (n) begin
			@(negedge clk);
			check_val("mem_cmd_o", 64'(mem_cmd), 64'(mem_pkg::CMD_NONE));
		end
	endtask

	task automatic wait_rsp(input int n);
		while (got_ptr_q.size() < n)
			@(posedge clk);
	endtask

	task automatic wait_stores(input int n);
		while (mem_i.store_cnt < n)
			@(negedge clk);
	endtask

	task automatic check_rsp(input logic [2:0] ptr, input logic [63:0] word);
		logic [2:0]  got_ptr;
		logic [63:0] got_word;
		got_ptr  = got_ptr_q.pop_front();
		got_word = got_data_q.pop_front();
		check_val("dmem_ctrl_rsp_ptr_o", 64'(got_ptr), 64'(ptr));
		check_val("dmem_ctrl_rsp_data_o", got_word, word);
	endtask

	//----------------------------------------
	// tests
	//----------------------------------------
	task automatic test_reset_state();
		repeat (3) begin
			@(negedge clk);
			#1;
			check_val("mem_cmd_o", 64'(mem_cmd), 64'(mem_pkg::CMD_NONE));
			check_val("dmem_ctrl_rsp_vld_o", 64'(rsp_vld), 64'd0);
			check_val("dmem_ctrl_rsp_ack_o", 64'(rsp_ack), 64'd0);
		end
	endtask

	task automatic test_load_clean();
		logic [12:0] line;
		logic [63:0] word;
		line = 13'($urandom);
		word = {$urandom, $urandom};
		mem_i.preload({line, 3'b000}, word);
		send_req(coh_pkg::GET_S, line, 64'd0, 1'b0, 3'd5, 1'b1);
		bus_idle();
		wait_rsp(1);
		check_rsp(3'd5, word);
	endtask

	task automatic test_own_writeback();
		logic [12:0] line;
		logic [63:0] word;
		logic [63:0] got;
		int          stores;
		line   = 13'($urandom);
		word   = {$urandom, $urandom};
		stores = mem_i.store_cnt;
		send_req(coh_pkg::GET_M, line, 64'd0, 1'b0, 3'd0, 1'b1);
		bus_idle();
		expect_quiet(6);   // ownership only, memory untouched
		send_req(coh_pkg::PUT_M, line, word, 1'b0, 3'd1, 1'b1);
		bus_idle();
		wait_stores(stores + 1);
		mem_i.read_word({line, 3'b000}, got);
		check_val("memory word", got, word);
		send_req(coh_pkg::GET_S, line, 64'd0, 1'b0, 3'd2, 1'b1);   // clean again
		bus_idle();
		wait_rsp(1);
		check_rsp(3'd2, word);
	endtask

	task automatic test_snoop_store();
		logic [12:0] line;
		logic [63:0] word;
		logic [63:0] got;
		int          stores;
		line   = 13'($urandom);
		word   = {$urandom, $urandom};
		stores = mem_i.store_cnt;
		send_req(coh_pkg::GET_M, line, 64'd0, 1'b0, 3'd0, 1'b1);
		bus_idle();
		send_req(coh_pkg::GET_S, line, 64'd0, 1'b1, 3'd3, 1'b1);
		bus_idle();
		expect_quiet(8);   // entry waits for the owner
		@(negedge clk);
		snp_vld  = 1'b1;
		snp_addr = {line, 3'b000};
		snp_data = word;
		@(negedge clk);
		snp_vld = 1'b0;
		wait_stores(stores + 1);
		mem_i.read_word({line, 3'b000}, got);
		check_val("memory word", got, word);
	endtask

	task automatic test_backpressure();
		logic [12:0] lines [5];
		logic [63:0] words [5];
		for (int i = 0; i < 5; i++) begin
			lines[i] = {10'($urandom), 3'(i)};
			words[i] = {$urandom, $urandom};
			mem_i.preload({lines[i], 3'b000}, words[i]);
		end
		@(negedge clk);
		stall = 1'b1;
		for (int i = 0; i < 4; i++)
			send_req(coh_pkg::GET_S, lines[i], 64'd0, 1'b0, 3'(i), 1'b1);
		send_req(coh_pkg::GET_S, lines[4], 64'd0, 1'b0, 3'd4, 1'b0);   // queue full
		@(negedge clk);
		stall = 1'b0;
		#1;
		check_val("dmem_ctrl_rsp_ack_o", 64'(rsp_ack), 64'd1);
		bus_idle();
		wait_rsp(5);
		for (int i = 0; i < 5; i++)
			check_rsp(3'(i), words[i]);
	endtask

	task automatic test_pipelined_loads();
		logic [12:0] lines [4];
		logic [63:0] words [4];
		for (int i = 0; i < 4; i++) begin
			lines[i] = {11'($urandom), 2'(i)};
			words[i] = {$urandom, $urandom};
			mem_i.preload({lines[i], 3'b000}, words[i]);
		end
		for (int i = 0; i < 4; i++)   // back to back
			send_req(coh_pkg::GET_S, lines[i], 64'd0, 1'b0, 3'(i + 4), 1'b1);
		bus_idle();
		wait_rsp(4);
		for (int i = 0; i < 4; i++)
			check_rsp(3'(i + 4), words[i]);
	endtask

	initial begin
		void'($urandom(32'h523e));
		rst          = 1'b1;
		req_line     = '0;
		req_msg      = coh_pkg::MSG_NONE;
		req_data     = '0;
		req_core_ack = 1'b0;
		req_ack      = 1'b0;
		req_ptr      = '0;
		snp_vld      = 1'b0;
		snp_addr     = '0;
		snp_data     = '0;
		stall        = 1'b0;
		repeat (3) @(posedge clk);   // three reset cycles
		@(negedge clk);
		rst = 1'b0;

		test_reset_state();
		test_load_clean();
		test_own_writeback();
		test_snoop_store();
		test_backpressure();
		test_pipelined_loads();
		expect_quiet(8);
		check_val("unclaimed responses", 64'(got_ptr_q.size()), 64'd0);

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: dmem_ctrl.f
src/coh_pkg.sv
src/mem_pkg.sv
src/mem_issue_if.sv
src/line_dir.sv
src/issue_queue.sv
src/response_queue.sv
src/dmem_ctrl.sv
sim/dmem_model.sv
sim/tb_dmem_ctrl.sv

// File: Makefile
TOP = tb_dmem_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f dmem_ctrl.f --top-module $(TOP)

sim:
	verilator --binary --timing -f dmem_ctrl.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
